/* common/ipod_pkg.sv */
`default_nettype none

package ipod_pkg;

  // ========================================
  // Widths and payload types
  // ========================================

  // Flash is word addressed, two 16-bit samples per word
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [7:0]  sample_t;
  typedef logic [15:0] period_t;
  typedef logic [7:0]  kbd_code_t;

  // ========================================
  // Command bytes (ASCII)
  // ========================================
  localparam kbd_code_t key_play     = 8'h45;  // E
  localparam kbd_code_t key_pause    = 8'h44;  // D
  localparam kbd_code_t key_backward = 8'h42;  // B
  localparam kbd_code_t key_forward  = 8'h46;  // F
  localparam kbd_code_t key_restart  = 8'h52;  // R

  // ========================================
  // Sample rate, in CLK_50M cycles
  // ========================================

  // About 22 kHz
  localparam period_t default_period = 16'd2272;
  localparam period_t period_step    = 16'd64;
  localparam period_t min_period     = 16'd1024;
  localparam period_t max_period     = 16'd8192;

  localparam flash_addr_t default_song_words = 23'h80000;

  // Flash reader FSM
  typedef enum logic [1:0] {
    idle,
    request,
    wait_data
  } read_state_e;

endpackage

`default_nettype wire

/* hw/sample_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_tick_gen
  import ipod_pkg::*;
(
  input  logic    CLK_50M,
  input  logic    rst,
  input  period_t period,
  output logic    sample_tick
);

  // Cycles left until the next tick
  period_t count;

  // Reload only on expiry, so a new period starts at the next tick
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count       <= period;
      sample_tick <= 1'b0;
    end
    else if (count <= 16'd1)
    begin
      count       <= period;
      sample_tick <= 1'b1;
    end
    else
    begin
      count       <= count - 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/speed_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module speed_ctrl
  import ipod_pkg::*;
(
  input  logic    CLK_50M,
  input  logic    rst,
  input  logic    speed_up_n,
  input  logic    speed_down_n,
  input  logic    speed_reset_n,
  output period_t period
);

  // Bit 0 up, bit 1 down, bit 2 reset; all idle high
  logic [2:0] btn_meta;
  logic [2:0] btn_sync;
  logic [2:0] btn_prev;
  logic [2:0] press;

  // ========================================
  // Synchroniser and press detect
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      btn_meta <= 3'b111;
      btn_sync <= 3'b111;
      btn_prev <= 3'b111;
    end
    else
    begin
      btn_meta <= {speed_reset_n, speed_down_n, speed_up_n};
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
    end
  end

  // Falling level = press
  assign press = btn_prev & ~btn_sync;

  // ========================================
  // Period register
  // ========================================

  // Reset beats up, up beats down
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      period <= default_period;
    else if (press[2])
      period <= default_period;
    else if (press[0])
      period <= (period >= min_period + period_step) ? period - period_step : min_period;
    else if (press[1])
      period <= (period + period_step <= max_period) ? period + period_step : max_period;
  end

endmodule

`default_nettype wire

/* hw/speed_display.sv */
`timescale 1ns/1ps
`default_nettype none

module speed_display
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  period_t    period,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5
);

  logic [23:0] shown;

  // Active low, bit 0 = segment a, bit 6 = segment g
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'b1000000;
      4'h1: seg7 = 7'b1111001;
      4'h2: seg7 = 7'b0100100;
      4'h3: seg7 = 7'b0110000;
      4'h4: seg7 = 7'b0011001;
      4'h5: seg7 = 7'b0010010;
      4'h6: seg7 = 7'b0000010;
      4'h7: seg7 = 7'b1111000;
      4'h8: seg7 = 7'b0000000;
      4'h9: seg7 = 7'b0010000;
      4'ha: seg7 = 7'b0001000;
      4'hb: seg7 = 7'b0000011;
      4'hc: seg7 = 7'b1000110;
      4'hd: seg7 = 7'b0100001;
      4'he: seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      shown <= {8'h00, default_period};
    else
      shown <= {8'h00, period};
  end

  // hex0 is the lowest nibble
  assign hex0 = seg7(shown[3:0]);
  assign hex1 = seg7(shown[7:4]);
  assign hex2 = seg7(shown[11:8]);
  assign hex3 = seg7(shown[15:12]);
  assign hex4 = seg7(shown[19:16]);
  assign hex5 = seg7(shown[23:20]);

endmodule

`default_nettype wire

/* playback/player_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module player_ctrl
  import ipod_pkg::*;
(
  input  logic      CLK_50M,
  input  logic      rst,
  input  kbd_code_t kbd_code,
  output logic      playing,
  output logic      forward,
  output logic      restart
);

  // Last command byte, for the restart edge
  kbd_code_t kbd_prev;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing  <= 1'b0;
      forward  <= 1'b1;
      restart  <= 1'b0;
      kbd_prev <= '0;
    end
    else
    begin
      kbd_prev <= kbd_code;
      restart  <= (kbd_code == key_restart) && (kbd_prev != key_restart);
      // Unknown codes keep the current state
      case (kbd_code)
        key_play:     playing <= 1'b1;
        key_pause:    playing <= 1'b0;
        key_forward:  forward <= 1'b1;
        key_backward: forward <= 1'b0;
        default:      ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* playback/flash_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_reader
  import ipod_pkg::*;
#(
  parameter flash_addr_t song_words = default_song_words
)
(
  input  logic        CLK_50M,
  input  logic        rst,
  input  logic        sample_tick,
  input  logic        playing,
  input  logic        forward,
  input  logic        restart,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output sample_t     audio_sample,
  output logic        sample_valid
);

  localparam flash_addr_t last_word = song_words - 23'd1;

  read_state_e state;

  // Position of the next sample to play
  flash_addr_t word_addr;
  logic        high_half;

  // Restart seen during a read, applied once back in idle
  logic        restart_pend;
  logic        restart_now;
  flash_addr_t restart_addr;
  logic        restart_half;

  assign restart_now  = restart | restart_pend;
  assign restart_addr = forward ? '0 : last_word;
  assign restart_half = ~forward;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= idle;
      word_addr     <= '0;
      high_half     <= 1'b0;
      restart_pend  <= 1'b0;
      flash_read    <= 1'b0;
      flash_address <= '0;
      audio_sample  <= '0;
      sample_valid  <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if (restart)
        restart_pend <= 1'b1;

      case (state)
        // ========================================
        idle:
        begin
          if (restart_now)
          begin
            word_addr    <= restart_addr;
            high_half    <= restart_half;
            restart_pend <= 1'b0;
          end
          if (sample_tick && playing)
          begin
            flash_read    <= 1'b1;
            flash_address <= restart_now ? restart_addr : word_addr;
            state         <= request;
          end
        end

        // Hold address and read until accepted
        request:
        begin
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= wait_data;
          end
        end

        // ========================================
        wait_data:
        begin
          if (flash_readdatavalid)
          begin
            // Audio byte is the upper byte of each half
            audio_sample <= high_half ? flash_readdata[31:24] : flash_readdata[15:8];
            sample_valid <= 1'b1;
            state        <= idle;
            if (forward)
            begin
              high_half <= ~high_half;
              if (high_half)
                word_addr <= (word_addr == last_word) ? '0 : word_addr + 23'd1;
            end
            else
            begin
              high_half <= ~high_half;
              if (!high_half)
                word_addr <= (word_addr == '0) ? last_word : word_addr - 23'd1;
            end
          end
        end

        default:
          state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/ipod_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ipod_top
  import ipod_pkg::*;
#(
  parameter flash_addr_t song_words = default_song_words
)
(
  input  logic        CLK_50M,
  input  logic        rst,
  input  kbd_code_t   kbd_code,
  input  logic        speed_up_n,
  input  logic        speed_down_n,
  input  logic        speed_reset_n,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output sample_t     audio_sample,
  output logic        sample_valid,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5,
  output logic        led_playing,
  output logic        led_forward
);

  period_t period;
  logic    sample_tick;
  logic    playing;
  logic    forward;
  logic    restart;

  assign led_playing = playing;
  assign led_forward = forward;

  // ========================================
  // Rate control and display
  // ========================================
  speed_ctrl speed_ctrl_i (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .speed_up_n    (speed_up_n),
    .speed_down_n  (speed_down_n),
    .speed_reset_n (speed_reset_n),
    .period        (period)
  );

  sample_tick_gen sample_tick_gen_i (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .period      (period),
    .sample_tick (sample_tick)
  );

  speed_display speed_display_i (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .period  (period),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

  // ========================================
  // Playback
  // ========================================
  player_ctrl player_ctrl_i (
    .CLK_50M  (CLK_50M),
    .rst      (rst),
    .kbd_code (kbd_code),
    .playing  (playing),
    .forward  (forward),
    .restart  (restart)
  );

  flash_reader #(
    .song_words (song_words)
  ) flash_reader_i (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .sample_tick         (sample_tick),
    .playing             (playing),
    .forward             (forward),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid)
  );

endmodule

`default_nettype wire

/* tb/ipod_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ipod_assert
  import ipod_pkg::*;
(
  input logic        CLK_50M,
  input logic        rst,
  input logic        flash_read,
  input flash_addr_t flash_address,
  input logic        flash_waitrequest,
  input logic        flash_readdatavalid,
  input logic        sample_valid,
  input period_t     period
);

  // ========================================
  // Flash request protocol
  // ========================================

  // A stalled request keeps its read strobe and address
  property request_held;
    @(posedge CLK_50M) disable iff (rst)
      (flash_read && flash_waitrequest) |=> (flash_read && $stable(flash_address));
  endproperty

  request_held_a: assert property (request_held)
    else $error("flash request changed while waitrequest was high");

  // Every sample comes from a returned flash word
  property sample_after_data;
    @(posedge CLK_50M) disable iff (rst)
      sample_valid |-> $past(flash_readdatavalid);
  endproperty

  sample_after_data_a: assert property (sample_after_data)
    else $error("sample_valid without a readdatavalid on the cycle before");

  // ========================================
  // Sample rate limits
  // ========================================
  property period_in_range;
    @(posedge CLK_50M) disable iff (rst)
      (period >= min_period) && (period <= max_period);
  endproperty

  period_in_range_a: assert property (period_in_range)
    else $error("sample period outside its allowed range");

endmodule

`default_nettype wire

/* tb/ipod_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ipod_tb
  import ipod_pkg::*;
();

  localparam flash_addr_t song_words = 23'd16;
  // Sample count of all tests, pause periods and speed presses included
  localparam longint test_samples = 110;
  localparam longint watchdog_ns = test_samples * 64'(max_period) * 64'd20 * 64'd2;

  // Digits that light each segment, bit n for digit n, segment a first
  localparam logic [15:0] lit_digits [7] = '{
    16'hD7ED, 16'h279F, 16'h2FFB, 16'h7B6D, 16'hFD45, 16'hDF71, 16'hEF7C
  };

  logic        CLK_50M;
  logic        rst;
  kbd_code_t   kbd_code;
  logic        speed_up_n;
  logic        speed_down_n;
  logic        speed_reset_n;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  sample_t     audio_sample;
  logic        sample_valid;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;
  logic        led_playing;
  logic        led_forward;

  // Flash model state
  int          wait_left;
  int          data_delay;
  logic        data_busy;
  flash_addr_t data_addr;

  // Received samples and the expected play position
  sample_t     samples [$];
  int          valid_count;
  flash_addr_t pos_word;
  logic        pos_high;
  logic        model_forward;

  int          checks;
  int          errors;
  int          test_errors;
  int          tests;
  int          exp_period;
  int          i;

  ipod_top #(
    .song_words (song_words)
  ) ipod_top_i (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .kbd_code            (kbd_code),
    .speed_up_n          (speed_up_n),
    .speed_down_n        (speed_down_n),
    .speed_reset_n       (speed_reset_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5),
    .led_playing         (led_playing),
    .led_forward         (led_forward)
  );

  bind ipod_top ipod_assert ipod_assert_i (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_valid        (sample_valid),
    .period              (period)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ========================================
  // Flash model
  // ========================================

  // Low half byte {a, 0}, high half byte {a, 1}
  function automatic flash_word_t flash_word_at(input flash_addr_t a);
    return {a[6:0], 1'b1, 8'h3c, a[6:0], 1'b0, 8'hc3};
  endfunction

  always @(posedge CLK_50M)
  begin : flash_model
    int stall;
    flash_readdatavalid <= 1'b0;
    if (rst)
    begin
      wait_left         <= 0;
      flash_waitrequest <= 1'b0;
      data_busy         <= 1'b0;
      data_delay        <= 0;
    end
    else
    begin
      if (flash_read && flash_waitrequest)
      begin
        if (wait_left <= 1)
          flash_waitrequest <= 1'b0;
        wait_left <= wait_left - 1;
      end
      else if (flash_read)
      begin
        // Accepted, so pick the stall of the next request now
        stall = int'($urandom_range(3, 0));
        wait_left         <= stall;
        flash_waitrequest <= (stall != 0);
        data_addr         <= flash_address;
        data_delay        <= int'($urandom_range(4, 1));
        data_busy         <= 1'b1;
      end
      if (data_busy)
      begin
        if (data_delay <= 1)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= flash_word_at(data_addr);
          data_busy           <= 1'b0;
        end
        else
          data_delay <= data_delay - 1;
      end
    end
  end

  always @(posedge CLK_50M)
  begin
    if (!rst && sample_valid)
    begin
      samples.push_back(audio_sample);
      valid_count <= valid_count + 1;
    end
  end

  // ========================================
  // Checks and stimulus helpers
  // ========================================
  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [6:0] segments_for(input logic [3:0] nib);
    logic [6:0] seg;
    for (int s = 0; s < 7; s++)
      seg[s] = ~lit_digits[s][nib];
    return seg;
  endfunction

  task automatic check_display(input int value, input string what);
    logic [6:0] digit [6];
    digit[0] = hex0;
    digit[1] = hex1;
    digit[2] = hex2;
    digit[3] = hex3;
    digit[4] = hex4;
    digit[5] = hex5;
    for (int d = 0; d < 6; d++)
      expect_eq(what, 32'(digit[d]), 32'(segments_for(4'(value >> (4 * d)))));
  endtask

  // Next play position after one sample
  task automatic advance_position();
    if (model_forward)
    begin
      if (pos_high)
        pos_word = (pos_word == song_words - 23'd1) ? '0 : pos_word + 23'd1;
    end
    else if (!pos_high)
      pos_word = (pos_word == '0) ? song_words - 23'd1 : pos_word - 23'd1;
    pos_high = ~pos_high;
  endtask

  task automatic check_samples(input int n, input string what);
    sample_t got;
    for (int k = 0; k < n; k++)
    begin
      while (samples.size() == 0)
        @(posedge CLK_50M);
      got = samples.pop_front();
      expect_eq(what, 32'(got), 32'({pos_word[6:0], pos_high}));
      advance_position();
    end
  endtask

  task automatic send_command(input kbd_code_t code);
    @(posedge CLK_50M);
    kbd_code <= code;
    repeat (2) @(posedge CLK_50M);
  endtask

  // 0 speed up, 1 speed down, 2 speed reset
  task automatic press_button(input int which);
    @(posedge CLK_50M);
    case (which)
      0: speed_up_n <= 1'b0;
      1: speed_down_n <= 1'b0;
      default: speed_reset_n <= 1'b0;
    endcase
    repeat (4) @(posedge CLK_50M);
    speed_up_n    <= 1'b1;
    speed_down_n  <= 1'b1;
    speed_reset_n <= 1'b1;
    repeat (6) @(posedge CLK_50M);
    @(negedge CLK_50M);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("[%0t ns] %s done, %0d errors", $time, name, errors - test_errors);
    test_errors = errors;
  endtask

  initial
  begin
    #(watchdog_ns);
    $display("watchdog: the run stalled, expected samples never arrived");
    $display("test failed");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================
  initial
  begin
    void'($urandom(32'hbb66));
    CLK_50M             = 1'b0;
    rst                 = 1'b1;
    kbd_code            = 8'h00;
    speed_up_n          = 1'b1;
    speed_down_n        = 1'b1;
    speed_reset_n       = 1'b1;
    flash_waitrequest   = 1'b0;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    valid_count         = 0;
    pos_word            = '0;
    pos_high            = 1'b0;
    model_forward       = 1'b1;
    repeat (10) @(posedge CLK_50M);
    rst <= 1'b0;

    repeat (3) @(negedge CLK_50M);
    expect_eq("flash_read after reset", 32'(flash_read), 32'd0);
    expect_eq("sample_valid after reset", 32'(sample_valid), 32'd0);
    expect_eq("audio_sample after reset", 32'(audio_sample), 32'd0);
    expect_eq("led_playing after reset", 32'(led_playing), 32'd0);
    expect_eq("led_forward after reset", 32'(led_forward), 32'd1);
    check_display(32'h0008E0, "display after reset");
    finish_test("reset");

    send_command(key_play);
    send_command(key_forward);
    expect_eq("led_playing after play", 32'(led_playing), 32'd1);
    check_samples(40, "forward sample");
    finish_test("forward play");

    // Pause during a read so that one more sample follows
    while (!flash_read)
      @(negedge CLK_50M);
    send_command(key_pause);
    check_samples(1, "sample after pause");
    @(negedge CLK_50M);
    i = valid_count;
    repeat (5 * int'(default_period)) @(posedge CLK_50M);
    @(negedge CLK_50M);
    expect_eq("samples while paused", 32'(valid_count), 32'(i));
    send_command(key_play);
    check_samples(4, "sample after resume");
    finish_test("pause");

    send_command(key_backward);
    model_forward = 1'b0;
    @(negedge CLK_50M);
    expect_eq("led_forward after backward", 32'(led_forward), 32'd0);
    check_samples(40, "backward sample");
    finish_test("backward play");

    send_command(key_forward);
    model_forward = 1'b1;
    check_samples(2, "forward sample");
    send_command(key_restart);
    pos_word = '0;
    pos_high = 1'b0;
    check_samples(3, "sample after forward restart");
    send_command(key_backward);
    model_forward = 1'b0;
    send_command(key_restart);
    pos_word = song_words - 23'd1;
    pos_high = 1'b1;
    check_samples(3, "sample after backward restart");
    finish_test("restart");

    send_command(key_pause);
    exp_period = int'(default_period);
    for (i = 0; i < 22; i++)
    begin
      press_button(0);
      exp_period = (exp_period - 64 < int'(min_period)) ? int'(min_period) : exp_period - 64;
      check_display(exp_period, "display after speed up");
    end
    for (i = 0; i < 114; i++)
    begin
      press_button(1);
      exp_period = (exp_period + 64 > int'(max_period)) ? int'(max_period) : exp_period + 64;
      check_display(exp_period, "display after speed down");
    end
    press_button(2);
    check_display(2272, "display after speed reset");
    finish_test("speed");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/ipod_pkg.sv
hw/sample_tick_gen.sv
hw/speed_ctrl.sv
hw/speed_display.sv
playback/player_ctrl.sv
playback/flash_reader.sv
hw/ipod_top.sv
tb/ipod_assert.sv
tb/ipod_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ipod_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
FAIL_MSG  ?= test failed
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
